// ==== Makefile ====
TOP = tbRtcMenu

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== bench/rtcChipModel.sv ====
`timescale 1ns/1ns

module rtcChipModel import rtcPkg::*;
(
	input  logic        CLK,
	input  rtcStrobes_t strobes,
	input  rtcData_t    adOut,
	input  logic        adOe,
	output rtcData_t    adIn
);

	rtcData_t mem [256];                // Register space, preloaded by the testbench
	rtcAddr_t addrLatch;                // Address taken during the latch window

	////////////////////////////////////////////////////////////////////////////
	// Multiplexed bus, address first and then data

	always @(posedge CLK)
	begin
		if (strobes.cs && strobes.ale && adOe)
			addrLatch <= adOut;
		if (strobes.cs && strobes.wr && adOe)
			mem[addrLatch] <= adOut;         // Same byte on every strobe cycle
	end

	// Chip drives the bus only while the read strobe is up and the host has let go
	assign adIn = (strobes.cs && strobes.rd && !adOe) ? mem[addrLatch] : 8'h00;

endmodule

// ==== bench/rtcMenu_sva.sv ====
`timescale 1ns/1ns

module rtcMenu_sva import rtcPkg::*;
(
	input logic        CLK,
	input logic        RST,
	input rtcStrobes_t strobes,
	input logic        accessStart,
	input logic        accessDone
);

	////////////////////////////////////////////////////////////////////////////
	// Chip bus strobes

	noReadWrite: assert property (@(posedge CLK) disable iff (RST)
		!(strobes.rd && strobes.wr))
		else $error("read and write strobes high together");

	strobeUnderSelect: assert property (@(posedge CLK) disable iff (RST)
		(strobes.ale || strobes.rd || strobes.wr) |-> strobes.cs)
		else $error("strobe high without chip select");

	latchApart: assert property (@(posedge CLK) disable iff (RST)
		!(strobes.ale && (strobes.rd || strobes.wr)))
		else $error("address latch overlaps a data strobe");

	// Handshake, done follows start after the fixed bus cycle
	startToDone: assert property (@(posedge CLK) disable iff (RST)
		accessStart |-> ##7 accessDone)
		else $error("access not finished seven cycles after its start");

	noStartOnDone: assert property (@(posedge CLK) disable iff (RST)
		accessDone |-> !accessStart)
		else $error("new access started on a done cycle");

endmodule

bind rtcMenuTop rtcMenu_sva uSva (
	.CLK(CLK), .RST(RST), .strobes(strobes),
	.accessStart(accessStart), .accessDone(accessDone)
);

// ==== bench/tbRtcMenu.sv ====
`timescale 1ns/1ns
`include "rtc_defs.svh"

module tbRtcMenu import rtcPkg::*;
();

	localparam int CYCLE  = 10;
	localparam int BUDGET = 40 * (12 * 8 + `RTC_WAIT_CYCLES + 1) + 40;   // In cycles
	localparam int LEFT   = 0;
	localparam int RIGHT  = 1;
	localparam int CENTER = 2;
	localparam int UP     = 3;
	localparam int DOWN   = 4;

	logic        CLK, RST;
	logic        btnLeft, btnRight, btnCenter, btnUp, btnDown;
	logic        irq, alarmStopIn;
	rtcData_t    adIn, adOut;
	logic        adOe;
	rtcStrobes_t strobes;
	menuPtr_t    pointer;
	logic        modifying, alarmStop;
	regView_t    view;

	logic [31:0] lfsr;
	int          errors = 0;
	rtcData_t    expMem [256];          // Shadow of the chip memory
	rtcData_t    expMirror [10];        // Expected mirror slots
	menuPtr_t    expPtr;
	rtcAddr_t    expAddr;               // Address of the access in flight
	logic        modeRef, centerPend, stopRef;
	logic        pendWrite, decidePend;
	rtcData_t    pendData;
	logic [4:0]  prevBtn;               // Left, right, center, up, down

	rtcMenuTop uut (
		.CLK(CLK), .RST(RST), .btnLeft(btnLeft), .btnRight(btnRight),
		.btnCenter(btnCenter), .btnUp(btnUp), .btnDown(btnDown), .irq(irq),
		.alarmStopIn(alarmStopIn), .adIn(adIn), .adOut(adOut), .adOe(adOe),
		.strobes(strobes), .pointer(pointer), .modifying(modifying),
		.alarmStop(alarmStop), .view(view)
	);

	rtcChipModel chip (
		.CLK(CLK), .strobes(strobes), .adOut(adOut), .adOe(adOe), .adIn(adIn)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference functions

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);   // Galois form
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsrStep(lfsr);
		end
		return r;
	endfunction

	function automatic rtcAddr_t sweepNext(input rtcAddr_t a, input logic pending);
		case (a)
			`RTC_INIT_ADDR, `RTC_CMD_ADDR: return `RTC_TIME_FIRST;
			`RTC_TIME_LAST:   return `RTC_TIMER_FIRST;
			`RTC_TIMER_LAST:  return pending ? `RTC_STATUS_ADDR : `RTC_CMD_ADDR;
			`RTC_STATUS_ADDR: return `RTC_CMD_ADDR;
			default:          return a + 8'd1;
		endcase
	endfunction

	function automatic menuPtr_t ptrNext(input menuPtr_t p, input logic left,
		input logic right, input logic center);
		int n;
		if (center)
			return 7'h21;
		n = int'(p) + int'(left) - int'(right);
		if (n == 'h27)
			n = 'h41;                        // Past the time group
		else if (n == 'h44)
			n = 'h21;
		else if (n == 'h20)
			n = 'h43;
		else if (n == 'h40)
			n = 'h26;
		return menuPtr_t'(n);
	endfunction

	function automatic int slotIndex(input rtcAddr_t a);
		if ((a >= 8'h21) && (a <= 8'h26))
			return int'(a) - 'h21;
		if ((a >= 8'h41) && (a <= 8'h43))
			return int'(a) - 'h41 + 6;
		if (a == 8'hF0)
			return 9;
		return -1;
	endfunction

	function automatic rtcAddr_t slotAddr(input int s);
		if (s < 6)
			return rtcAddr_t'('h21 + s);
		if (s < 9)
			return rtcAddr_t'('h41 + s - 6);
		return 8'hF0;
	endfunction

	function automatic rtcData_t viewByte(input regView_t v, input int s);
		if (s < 6)
			return v.timeDate[s];
		if (s < 9)
			return v.timer[s - 6];
		return v.cmd;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Check, stimulus and wait helpers

	task automatic check(input logic [79:0] got, input logic [79:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic driveButton(input int which, input logic level);
		case (which)
			LEFT:    btnLeft   = level;
			RIGHT:   btnRight  = level;
			CENTER:  btnCenter = level;
			UP:      btnUp     = level;
			default: btnDown   = level;
		endcase
	endtask

	// Two cycles high, then low across at least one edge
	task automatic press(input int which);
		@(posedge CLK);
		#1 driveButton(which, 1'b1);
		repeat (2) @(posedge CLK);
		#1 driveButton(which, 1'b0);
	endtask

	task automatic waitAccess(input rtcAddr_t a);
		do
			@(negedge CLK);
		while (!(uut.accessDone && (uut.busResult.addr == a)));
	endtask

	task automatic checkMemory();
		#1;                                  // Shadow memory has taken this edge's access
		for (int s = 0; s < 10; s++)
			check(80'(viewByte(view, s)), 80'(chip.mem[slotAddr(s)]), "view against chip");
		for (int a = 0; a < 256; a++)
			check(80'(chip.mem[a]), 80'(expMem[a]), "chip memory");
	endtask

	task automatic resetReference();
		for (int s = 0; s < 10; s++)
			expMirror[s] = 8'h00;
		expPtr     = 7'h21;
		expAddr    = `RTC_INIT_ADDR;
		modeRef    = 1'b1;                 // First sweep writes
		centerPend = 1'b0;
		decidePend = 1'b0;
		stopRef    = 1'b0;
		pendWrite  = 1'b1;
		pendData   = `RTC_INIT_DATA;
		prevBtn    = 5'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process, runs on the falling edge where everything is stable

	always @(negedge CLK)
	begin
		logic     left, right, center, up, down, done;
		rtcAddr_t doneAddr;
		int       s;
		if (RST)
			resetReference();
		else
		begin
			left     = btnLeft && !prevBtn[4];
			right    = btnRight && !prevBtn[3];
			center   = btnCenter && !prevBtn[2];
			up       = btnUp && !prevBtn[1];
			down     = btnDown && !prevBtn[0];
			done     = uut.accessDone;
			doneAddr = uut.busResult.addr;
			check(80'(pointer), 80'(expPtr), "pointer");
			check(80'(alarmStop), 80'(stopRef), "alarmStop");
			for (int i = 0; i < 10; i++)
				check(80'(viewByte(view, i)), 80'(expMirror[i]), "view byte");
			if (uut.accessStart)               // Data is taken from the mirror now
			begin
				if (decidePend)                 // Center edges of the sweep and the wait
				begin
					modeRef    = centerPend;
					centerPend = 1'b0;
					decidePend = 1'b0;
				end
				s         = slotIndex(expAddr);
				pendWrite = modeRef || (expAddr == `RTC_STATUS_ADDR) || (expAddr == `RTC_CMD_ADDR);
				pendData  = (s >= 0) ? expMirror[s] : 8'h00;
			end
			check(80'(modifying), 80'(modeRef), "modifying");
			centerPend = centerPend || center;
			if (done)
			begin
				check(80'(doneAddr), 80'(expAddr), "access address");
				check(80'(uut.ctrlReq.write), 80'(pendWrite), "write flag");
				if (pendWrite)
				begin
					check(80'(uut.busResult.data), 80'(pendData), "write data");
					expMem[doneAddr] = pendData;
				end
				else
					check(80'(uut.busResult.data), 80'(expMem[doneAddr]), "read data");
				if (doneAddr == `RTC_CMD_ADDR)
				begin
					modeRef    = 1'b0;            // Reads through the wait
					decidePend = 1'b1;
				end
				expAddr = sweepNext(doneAddr, irq);
			end
			// Edit first, then a read capture on the same slot overrides it
			s = slotIndex({1'b0, expPtr});
			if ((s >= 0) && (up || down))
				expMirror[s] = expMirror[s] + 8'(up) - 8'(down);
			s = slotIndex(doneAddr);
			if (done && !pendWrite && (s >= 0))
				expMirror[s] = expMem[doneAddr];
			expPtr  = ptrNext(expPtr, left, right, center);
			stopRef = irq && alarmStopIn;
			prevBtn = {btnLeft, btnRight, btnCenter, btnUp, btnDown};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Clock, watchdog and stimulus

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial
	begin
		#(BUDGET * CYCLE);
		$display("Finished with errors");
		$fatal(1, "Timeout, the DUT stopped answering within the cycle budget");
	end

	initial
	begin
		rtcData_t b;
		int       steps;
		logic     op;
		RST         = 1'b1;
		btnLeft     = 1'b0;
		btnRight    = 1'b0;
		btnCenter   = 1'b0;
		btnUp       = 1'b0;
		btnDown     = 1'b0;
		irq         = 1'b0;
		alarmStopIn = 1'b0;
		lfsr        = 32'h2711fb93;
		for (int i = 0; i < 256; i++)
		begin
			b           = rtcData_t'(randBits(8));
			chip.mem[i] = b;
			expMem[i]   = b;
		end
		repeat (5) @(posedge CLK);
		#1 RST = 1'b0;

		// Init write, first write sweep, then one read sweep
		waitAccess(`RTC_CMD_ADDR);
		waitAccess(`RTC_CMD_ADDR);
		checkMemory();

		// Full loop each way crosses both gaps
		repeat (10) press(LEFT);
		repeat (10) press(RIGHT);

		// Chain write sweeps so that edits are not overwritten by reads
		waitAccess(8'h23);
		press(CENTER);
		waitAccess(`RTC_CMD_ADDR);
		waitAccess(8'h23);
		press(CENTER);
		repeat (3)
		begin
			steps = int'(randBits(2));
			repeat (steps) press(LEFT);
			steps = int'(randBits(1)) + 1;
			op    = 1'(randBits(1));
			repeat (steps) press(op ? UP : DOWN);
		end
		waitAccess(8'h23);
		press(CENTER);
		waitAccess(`RTC_CMD_ADDR);
		waitAccess(`RTC_CMD_ADDR);
		check(80'(pointer), 80'(7'h21), "pointer after center");
		checkMemory();

		// Pending timer interrupt adds the status clear
		@(posedge CLK);
		#1 irq = 1'b1;
		alarmStopIn = 1'b1;
		waitAccess(`RTC_STATUS_ADDR);
		waitAccess(`RTC_CMD_ADDR);
		@(posedge CLK);
		#1 alarmStopIn = 1'b0;
		@(posedge CLK);
		#1 irq = 1'b0;
		waitAccess(`RTC_CMD_ADDR);
		checkMemory();

		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/rtcPkg.sv
rtl/menuControl.sv
rtl/rtcBusCycle.sv
rtl/timeRegFile.sv
rtl/rtcMenuTop.sv
bench/rtcChipModel.sv
bench/rtcMenu_sva.sv
bench/tbRtcMenu.sv

// ==== rtl/menuControl.sv ====
`timescale 1ns/1ns
`include "rtc_defs.svh"

module menuControl import rtcPkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     irq,             // Timer interrupt from the chip
	input  logic     btnLeft,
	input  logic     btnRight,
	input  logic     btnCenter,
	input  logic     alarmStopIn,
	input  logic     accessDone,
	output logic     accessStart,
	output busReq_t  accessReq,
	output logic     modifying,
	output menuPtr_t pointer,
	output logic     stopWatch
);

	mainState_t  mainState, mainNext;
	sweepState_t sweepState;
	waitState_t  waitState;

	logic [2:0] btnPrev;                // Left, right, center of the previous cycle
	logic       leftEdge, rightEdge, centerEdge;
	logic       centerLatched;          // Center seen since the last write decision
	logic       centerTake;
	logic       modNext;
	logic       sweepGo, sweepDone;
	logic       waitGo, waitDone;
	logic [2:0] waitCnt;
	rtcAddr_t   reqAddr, stepAddr;
	logic       reqWrite;

	// Next address of the sweep, gaps are skipped
	function automatic rtcAddr_t nextAddr(rtcAddr_t a, logic pending);
		rtcAddr_t n;
		case (a)
			`RTC_TIME_LAST:   n = `RTC_TIMER_FIRST;
			`RTC_TIMER_LAST:  n = pending ? `RTC_STATUS_ADDR : `RTC_CMD_ADDR;
			`RTC_STATUS_ADDR: n = `RTC_CMD_ADDR;
			default:          n = a + 8'd1;
		endcase
		return n;
	endfunction

	// Status clear and transfer command always write
	function automatic logic writeFor(rtcAddr_t a, logic mode);
		return mode || (a == `RTC_STATUS_ADDR) || (a == `RTC_CMD_ADDR);
	endfunction

	// Pointer step with wrap across the register groups
	function automatic menuPtr_t ptrStep(menuPtr_t p, logic inc, logic dec);
		menuPtr_t t;
		t = p + menuPtr_t'(inc) - menuPtr_t'(dec);
		case (t)
			menuPtr_t'(`RTC_TIME_LAST + 1):   t = menuPtr_t'(`RTC_TIMER_FIRST);
			menuPtr_t'(`RTC_TIMER_LAST + 1):  t = menuPtr_t'(`RTC_TIME_FIRST);
			menuPtr_t'(`RTC_TIME_FIRST - 1):  t = menuPtr_t'(`RTC_TIMER_LAST);
			menuPtr_t'(`RTC_TIMER_FIRST - 1): t = menuPtr_t'(`RTC_TIME_LAST);
			default: ;
		endcase
		return t;
	endfunction

	assign leftEdge   = btnLeft   && !btnPrev[2];
	assign rightEdge  = btnRight  && !btnPrev[1];
	assign centerEdge = btnCenter && !btnPrev[0];

	////////////////////////////////////////////////////////////////////////////
	// Main machine

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			mainState     <= MAIN_INIT;
			modifying     <= 1'b1;         // First sweep pushes the mirror out
			centerLatched <= 1'b0;
			btnPrev       <= 3'b000;
			stopWatch     <= 1'b0;
		end
		else
		begin
			mainState <= mainNext;
			modifying <= modNext;
			btnPrev   <= {btnLeft, btnRight, btnCenter};
			stopWatch <= irq && alarmStopIn;
			if (centerTake)
				centerLatched <= 1'b0;        // Edge in this cycle already in modNext
			else if (centerEdge)
				centerLatched <= 1'b1;
		end
	end

	always_comb
	begin
		mainNext   = mainState;
		modNext    = modifying;
		sweepGo    = 1'b0;
		waitGo     = 1'b0;
		centerTake = 1'b0;
		case (mainState)
			MAIN_INIT:
				if (accessDone)                 // Init write finished
				begin
					sweepGo  = 1'b1;
					mainNext = MAIN_SWEEP;
				end
			MAIN_SWEEP:
				if (sweepDone)
				begin
					modNext  = 1'b0;
					waitGo   = 1'b1;
					mainNext = MAIN_WAIT;
				end
			MAIN_WAIT:
				if (waitDone)
				begin
					sweepGo    = 1'b1;
					centerTake = 1'b1;
					modNext    = centerLatched || centerEdge;
					mainNext   = MAIN_SWEEP;
				end
			default: mainNext = MAIN_INIT;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Sweep count machine

	assign stepAddr  = nextAddr(reqAddr, irq);
	assign sweepDone = (sweepState == SWEEP_BUSY) && accessDone && (reqAddr == `RTC_CMD_ADDR);

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			sweepState  <= SWEEP_IDLE;
			accessStart <= 1'b0;
			reqAddr     <= `RTC_INIT_ADDR;  // Matches the access run after reset
			reqWrite    <= 1'b1;
		end
		else
		begin
			accessStart <= 1'b0;
			case (sweepState)
				SWEEP_IDLE:
					if (sweepGo)
					begin
						sweepState  <= SWEEP_BUSY;
						accessStart <= 1'b1;
						reqAddr     <= `RTC_TIME_FIRST;
						reqWrite    <= writeFor(`RTC_TIME_FIRST, modNext);
					end
				SWEEP_BUSY:
					if (sweepDone)
						sweepState <= SWEEP_IDLE;
					else if (accessDone)
					begin
						accessStart <= 1'b1;         // Back to back, one cycle after done
						reqAddr     <= stepAddr;
						reqWrite    <= writeFor(stepAddr, modifying);
					end
				default: sweepState <= SWEEP_IDLE;
			endcase
		end
	end

	always_comb
	begin
		accessReq.addr  = reqAddr;
		accessReq.write = reqWrite;
		accessReq.data  = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Wait counter between sweeps

	assign waitDone = (waitState == WAIT_COUNT) && (waitCnt == 3'(`RTC_WAIT_CYCLES));

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			waitState <= WAIT_IDLE;
			waitCnt   <= 3'd1;
		end
		else
		begin
			case (waitState)
				WAIT_IDLE:
					if (waitGo)
						waitState <= WAIT_COUNT;
				WAIT_COUNT:
					if (waitDone)
					begin
						waitState <= WAIT_IDLE;
						waitCnt   <= 3'd1;
					end
					else
						waitCnt <= waitCnt + 3'd1;
				default: waitState <= WAIT_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointer machine

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			pointer <= menuPtr_t'(`RTC_TIME_FIRST);
		else if (centerEdge)
			pointer <= menuPtr_t'(`RTC_TIME_FIRST);    // Edit at old pointer still lands
		else
			pointer <= ptrStep(pointer, leftEdge, rightEdge);
	end

endmodule

// ==== rtl/rtcBusCycle.sv ====
`timescale 1ns/1ns
`include "rtc_defs.svh"

module rtcBusCycle import rtcPkg::*;
(
	input  logic        CLK,
	input  logic        RST,
	input  logic        accessStart,
	input  busReq_t     accessReq,
	input  rtcData_t    adIn,
	output logic        accessDone,
	output busResult_t  busResult,
	output rtcData_t    adOut,
	output logic        adOe,
	output rtcStrobes_t strobes
);

	busPhase_t  phase;
	logic [2:0] phaseCnt;
	logic       latchLast, strobeLast;
	busReq_t    curReq;                 // Request held for the whole access
	rtcData_t   rdData;

	assign latchLast  = (phaseCnt == 3'(`RTC_LATCH_CYCLES - 1));
	assign strobeLast = (phaseCnt == 3'(`RTC_STROBE_CYCLES - 1));

	////////////////////////////////////////////////////////////////////////////
	// Phase sequencer

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			phase    <= BUS_INIT;          // Init write runs before any request
			phaseCnt <= 3'd0;
		end
		else
		begin
			case (phase)
				BUS_INIT:
				begin
					phase    <= BUS_LATCH;
					phaseCnt <= 3'd0;
				end
				BUS_IDLE:
					if (accessStart)
					begin
						phase    <= BUS_LATCH;
						phaseCnt <= 3'd0;
					end
				BUS_LATCH:
					if (latchLast)
					begin
						phase    <= BUS_STROBE;
						phaseCnt <= 3'd0;
					end
					else
						phaseCnt <= phaseCnt + 3'd1;
				BUS_STROBE:
					if (strobeLast)
						phase <= BUS_DONE;
					else
						phaseCnt <= phaseCnt + 3'd1;
				BUS_DONE: phase <= BUS_IDLE;    // Done pulse, one cycle
				default:  phase <= BUS_IDLE;
			endcase
		end
	end

	// Request and read byte capture
	always_ff @(posedge CLK)
	begin
		if (phase == BUS_INIT)
		begin
			curReq.addr  <= `RTC_INIT_ADDR;
			curReq.write <= 1'b1;
			curReq.data  <= `RTC_INIT_DATA;
		end
		else if ((phase == BUS_IDLE) && accessStart)
			curReq <= accessReq;
		if ((phase == BUS_STROBE) && strobeLast && !curReq.write)
			rdData <= adIn;                  // Sampled at the end of the strobe
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus outputs, decoded from the phase

	always_comb
	begin
		strobes.cs  = (phase == BUS_LATCH) || (phase == BUS_STROBE);
		strobes.ale = (phase == BUS_LATCH);
		strobes.rd  = (phase == BUS_STROBE) && !curReq.write;
		strobes.wr  = (phase == BUS_STROBE) && curReq.write;
		adOe        = strobes.ale || strobes.wr;   // Released while the chip drives
		adOut       = strobes.ale ? curReq.addr : curReq.data;
	end

	assign accessDone     = (phase == BUS_DONE);
	assign busResult.addr = curReq.addr;
	assign busResult.data = curReq.write ? curReq.data : rdData;  // Write echoes its byte

endmodule

// ==== rtl/rtcMenuTop.sv ====
`timescale 1ns/1ns

module rtcMenuTop import rtcPkg::*;
(
	input  logic        CLK,
	input  logic        RST,
	input  logic        btnLeft,
	input  logic        btnRight,
	input  logic        btnCenter,
	input  logic        btnUp,
	input  logic        btnDown,
	input  logic        irq,
	input  logic        alarmStopIn,
	input  rtcData_t    adIn,
	output rtcData_t    adOut,
	output logic        adOe,
	output rtcStrobes_t strobes,
	output menuPtr_t    pointer,
	output logic        modifying,
	output logic        alarmStop,
	output regView_t    view
);

	logic       accessStart, accessDone;
	busReq_t    ctrlReq, busReq;
	busResult_t busResult;
	rtcData_t   writeData;

	// Mirror byte joins the request on its way to the bus
	always_comb
	begin
		busReq      = ctrlReq;
		busReq.data = writeData;
	end

	menuControl uMenu (
		.CLK(CLK), .RST(RST), .irq(irq),
		.btnLeft(btnLeft), .btnRight(btnRight), .btnCenter(btnCenter),
		.alarmStopIn(alarmStopIn), .accessDone(accessDone),
		.accessStart(accessStart), .accessReq(ctrlReq),
		.modifying(modifying), .pointer(pointer), .stopWatch(alarmStop)
	);

	rtcBusCycle uBus (
		.CLK(CLK), .RST(RST), .accessStart(accessStart), .accessReq(busReq),
		.adIn(adIn), .accessDone(accessDone), .busResult(busResult),
		.adOut(adOut), .adOe(adOe), .strobes(strobes)
	);

	timeRegFile uRegs (
		.CLK(CLK), .RST(RST), .pointer(pointer), .btnUp(btnUp), .btnDown(btnDown),
		.reqAddr(ctrlReq.addr), .accessDone(accessDone), .busResult(busResult),
		.readWasWrite(ctrlReq.write),      // Request still held on the done pulse
		.writeData(writeData), .view(view)
	);

endmodule

// ==== rtl/rtcPkg.sv ====
package rtcPkg;

	typedef logic [7:0] rtcAddr_t;      // Chip register address
	typedef logic [7:0] rtcData_t;      // Chip register byte
	typedef logic [6:0] menuPtr_t;      // Edit pointer, chip address without bit 7

	// Access request toward the bus cycle block
	typedef struct packed {
		rtcAddr_t addr;
		logic     write;                // High for a write access
		rtcData_t data;                 // Filled in at the top from the mirror
	} busReq_t;

	typedef struct packed {
		rtcAddr_t addr;
		rtcData_t data;                 // Valid together with the done pulse
	} busResult_t;

	typedef struct packed {
		logic cs;                       // Chip select
		logic ale;                      // Address latch
		logic rd;
		logic wr;
	} rtcStrobes_t;

	// Mirror contents, index 0 of each group is its lowest address
	typedef struct packed {
		rtcData_t [5:0] timeDate;       // 0x21..0x26
		rtcData_t [2:0] timer;          // 0x41..0x43
		rtcData_t       cmd;            // 0xF0
	} regView_t;

	typedef enum logic [1:0] {MAIN_INIT, MAIN_SWEEP, MAIN_WAIT} mainState_t;
	typedef enum logic {SWEEP_IDLE, SWEEP_BUSY} sweepState_t;
	typedef enum logic {WAIT_IDLE, WAIT_COUNT} waitState_t;
	typedef enum logic [2:0] {BUS_INIT, BUS_IDLE, BUS_LATCH, BUS_STROBE, BUS_DONE} busPhase_t;

endpackage

// ==== rtl/rtc_defs.svh ====
`ifndef RTC_DEFS_SVH
`define RTC_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Chip register map

`define RTC_INIT_ADDR     8'h02     // Init access target, sets the digital trim
`define RTC_INIT_DATA     8'h10
`define RTC_STATUS_ADDR   8'h00     // Cleared when the timer interrupt is pending
`define RTC_CMD_ADDR      8'hF0     // Transfer command, RAM to clock registers

// Time and date group
`define RTC_TIME_FIRST    8'h21
`define RTC_TIME_LAST     8'h26

// Countdown timer group
`define RTC_TIMER_FIRST   8'h41
`define RTC_TIMER_LAST    8'h43

////////////////////////////////////////////////////////////////////////////
// Timing, in clock cycles

`define RTC_WAIT_CYCLES   3         // Idle gap between two sweeps
`define RTC_LATCH_CYCLES  2         // Address latch window
`define RTC_STROBE_CYCLES 4         // Read or write strobe window

`endif

// ==== rtl/timeRegFile.sv ====
`timescale 1ns/1ns
`include "rtc_defs.svh"

module timeRegFile import rtcPkg::*;
(
	input  logic       CLK,
	input  logic       RST,
	input  menuPtr_t   pointer,
	input  logic       btnUp,
	input  logic       btnDown,
	input  rtcAddr_t   reqAddr,
	input  logic       accessDone,
	input  busResult_t busResult,
	input  logic       readWasWrite,
	output rtcData_t   writeData,
	output regView_t   view
);

	rtcData_t   regs [10];              // Slots 0..5 time, 6..8 timer, 9 command
	logic       upPrev, downPrev;
	logic       upEdge, downEdge;
	logic [4:0] ptrSlot, capSlot, reqSlot;   // Bit 4 is the hit flag
	logic       capture;

	// Address to slot map
	function automatic logic [4:0] slotOf(rtcAddr_t a);
		logic [4:0] s;
		s = 5'd0;
		if ((a >= `RTC_TIME_FIRST) && (a <= `RTC_TIME_LAST))
			s = {1'b1, 4'(a - `RTC_TIME_FIRST)};
		else if ((a >= `RTC_TIMER_FIRST) && (a <= `RTC_TIMER_LAST))
			s = {1'b1, 4'(a - `RTC_TIMER_FIRST + 8'd6)};
		else if (a == `RTC_CMD_ADDR)
			s = {1'b1, 4'd9};
		return s;
	endfunction

	assign upEdge   = btnUp && !upPrev;
	assign downEdge = btnDown && !downPrev;
	assign ptrSlot  = slotOf({1'b0, pointer});
	assign capSlot  = slotOf(busResult.addr);
	assign reqSlot  = slotOf(reqAddr);
	assign capture  = accessDone && !readWasWrite && capSlot[4];

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			upPrev   <= 1'b0;
			downPrev <= 1'b0;
			for (int i = 0; i < 10; i++)
				regs[i] <= '0;
		end
		else
		begin
			upPrev   <= btnUp;
			downPrev <= btnDown;
			if (ptrSlot[4] && (upEdge || downEdge))
				regs[ptrSlot[3:0]] <= regs[ptrSlot[3:0]] + rtcData_t'(upEdge)
					- rtcData_t'(downEdge);      // Plain binary, wraps mod 256
			if (capture)
				regs[capSlot[3:0]] <= busResult.data;  // Read result beats a same-cycle edit
		end
	end

	// Unknown addresses, status clear included, send zero
	assign writeData = reqSlot[4] ? regs[reqSlot[3:0]] : '0;

	always_comb
	begin
		for (int i = 0; i < 6; i++)
			view.timeDate[i] = regs[i];
		for (int i = 0; i < 3; i++)
			view.timer[i] = regs[6 + i];
		view.cmd = regs[9];
	end

endmodule
